/* logic/timetag_settings.svh */
`ifndef TIMETAG_SETTINGS_SVH
`define TIMETAG_SETTINGS_SVH

// Returned by the version register
`define TIMETAG_VERSION 32'h5454_0100

// Records held in the FIFO, a power of two
`define TIMETAG_FIFO_DEPTH 8

// Free-running timestamp counter
`define TIMETAG_TIMER_WIDTH 36

// Strobe inputs, one mask bit each
`define TIMETAG_CHANNELS 4

`endif

/* logic/timetag_pkg.sv */
`include "timetag_settings.svh"

package timetag_pkg;

	// One bit per strobe channel
	typedef logic [`TIMETAG_CHANNELS-1:0] chan_mask_t;

	// Tag record, sent MSB first as six bytes
	typedef struct packed {
		chan_mask_t mask;
		logic [7:0] seq;
		logic [`TIMETAG_TIMER_WIDTH-1:0] stamp;
	} record_t;

	// Bytes per record on the FX2 port
	localparam int record_bytes = $bits(record_t) / 8;

	// APB register map
	localparam logic [7:0] reg_version = 8'h00;
	// Bit 0 run, bit 1 clears the timer and reads back zero
	localparam logic [7:0] reg_control = 8'h04;
	localparam logic [7:0] reg_enable = 8'h08;
	// Records lost to a full FIFO, any write clears
	localparam logic [7:0] reg_lost = 8'h0C;

endpackage

/* logic/tagger_regs.sv */
`timescale 1ns/1ps
`include "timetag_settings.svh"

module tagger_regs (
	input  logic                    fx2_clk,
	input  logic                    rst,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  logic [7:0]              paddr,
	input  logic [31:0]             pwdata,
	input  logic                    drop,
	output logic [31:0]             prdata,
	output logic                    pready,
	output logic                    pslverr,
	output logic                    run,
	output timetag_pkg::chan_mask_t enable,
	output logic                    clear_timer
);
	import timetag_pkg::*;

	logic        access;
	logic        wr_en;
	logic        mapped;
	logic [31:0] lost_count;

	// No wait states, every transfer ends in its access phase
	assign access = psel & penable;
	assign wr_en = access & pwrite;
	assign pready = 1'b1;

	// Read mux and address decode
	always_comb begin
		mapped = 1'b1;
		case (paddr)
			reg_version: prdata = `TIMETAG_VERSION;
			reg_control: prdata = {31'd0, run};
			reg_enable: prdata = {{(32 - `TIMETAG_CHANNELS){1'b0}}, enable};
			reg_lost: prdata = lost_count;
			default: begin
				prdata = 32'd0;
				mapped = 1'b0;
			end
		endcase
	end

	assign pslverr = access & ~mapped;

	always_ff @(posedge fx2_clk) begin
		if (rst) begin
			run <= 1'b0;
			enable <= '0;
			clear_timer <= 1'b0;
		end else begin
			// Clear is a single cycle pulse
			clear_timer <= 1'b0;
			if (wr_en && paddr == reg_control) begin
				run <= pwdata[0];
				clear_timer <= pwdata[1];
			end
			if (wr_en && paddr == reg_enable) begin
				enable <= pwdata[`TIMETAG_CHANNELS-1:0];
			end
		end
	end

	// Lost record counter, sticks at all ones
	always_ff @(posedge fx2_clk) begin
		if (rst) begin
			lost_count <= '0;
		end else if (wr_en && paddr == reg_lost) begin
			lost_count <= '0;
		end else if (drop && lost_count != '1) begin
			lost_count <= lost_count + 32'd1;
		end
	end

endmodule

/* logic/strobe_tagger.sv */
`timescale 1ns/1ps
`include "timetag_settings.svh"

module strobe_tagger (
	input  logic                    fx2_clk,
	input  logic                    rst,
	input  timetag_pkg::chan_mask_t strobe_in,
	input  logic                    run,
	input  timetag_pkg::chan_mask_t enable,
	input  logic                    clear_timer,
	input  logic                    full,
	output logic                    rec_valid,
	output timetag_pkg::record_t    rec
);
	import timetag_pkg::*;

	chan_mask_t sync1;
	chan_mask_t sync2;
	chan_mask_t sync2_d;
	chan_mask_t hits;
	chan_mask_t mask_q;
	logic [`TIMETAG_TIMER_WIDTH-1:0] timer;
	logic [`TIMETAG_TIMER_WIDTH-1:0] stamp_q;
	logic [7:0] seq;

	// Two flop synchronizer plus one delay stage for the edge detect
	always_ff @(posedge fx2_clk) begin
		if (rst) begin
			sync1 <= '0;
			sync2 <= '0;
			sync2_d <= '0;
		end else begin
			sync1 <= strobe_in;
			sync2 <= sync1;
			sync2_d <= sync2;
		end
	end

	// Rising edges on enabled channels only
	assign hits = sync2 & ~sync2_d & enable;

	// Timer holds while stopped
	always_ff @(posedge fx2_clk) begin
		if (rst || clear_timer) begin
			timer <= '0;
		end else if (run) begin
			timer <= timer + 1'b1;
		end
	end

	// One record per cycle with any edge, masks combined
	always_ff @(posedge fx2_clk) begin
		if (rst) begin
			rec_valid <= 1'b0;
		end else begin
			rec_valid <= run & (|hits);
		end
	end

	// Stamp is taken in the edge-detect cycle
	always_ff @(posedge fx2_clk) begin
		mask_q <= hits;
		stamp_q <= timer;
	end

	// Sequence only advances on records the FIFO accepts
	always_ff @(posedge fx2_clk) begin
		if (rst) begin
			seq <= '0;
		end else if (rec_valid && !full) begin
			seq <= seq + 8'd1;
		end
	end

	always_comb begin
		rec.mask = mask_q;
		rec.seq = seq;
		rec.stamp = stamp_q;
	end

endmodule

/* logic/record_fifo.sv */
`timescale 1ns/1ps
`include "timetag_settings.svh"

module record_fifo #(
	parameter int depth = `TIMETAG_FIFO_DEPTH
) (
	input  logic                 fx2_clk,
	input  logic                 rst,
	input  logic                 push,
	input  timetag_pkg::record_t din,
	input  logic                 pop,
	output timetag_pkg::record_t dout,
	output logic                 empty,
	output logic                 full,
	output logic                 drop
);
	import timetag_pkg::*;

	localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;

	record_t mem [depth];
	logic [ptr_width-1:0] wr_ptr;
	logic [ptr_width-1:0] rd_ptr;
	logic [ptr_width:0]   count;
	logic                 do_push;
	logic                 do_pop;

	assign full = (count == (ptr_width + 1)'(depth));
	assign empty = (count == '0);
	// Push into a full buffer is lost
	assign drop = push & full;
	assign do_push = push & ~full;
	assign do_pop = pop & ~empty;
	assign dout = mem[rd_ptr];

	always_ff @(posedge fx2_clk) begin
		if (do_push) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge fx2_clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* logic/fx2_record_writer.sv */
`timescale 1ns/1ps

module fx2_record_writer (
	input  logic                 fx2_clk,
	input  logic                 rst,
	input  logic                 empty,
	input  timetag_pkg::record_t head,
	input  logic                 full_n,
	output logic                 pop,
	output logic [7:0]           fd,
	output logic                 slwr_n
);
	import timetag_pkg::*;

	record_t    hold;
	logic       busy;
	logic [2:0] idx;
	logic       last;

	// Take a new record only once the previous one is fully sent
	assign pop = ~busy & ~empty;
	assign last = (idx == 3'(record_bytes - 1));

	// Strobe only while the FX2 has room
	assign slwr_n = ~(busy & full_n);

	// Byte 0 is the most significant one
	assign fd = hold[8 * (record_bytes - 1 - int'(idx)) +: 8];

	always_ff @(posedge fx2_clk) begin
		if (pop) begin
			hold <= head;
		end
	end

	always_ff @(posedge fx2_clk) begin
		if (rst) begin
			busy <= 1'b0;
			idx <= '0;
		end else if (pop) begin
			busy <= 1'b1;
			idx <= '0;
		end else if (busy && full_n) begin
			// Byte went out this cycle
			if (last) begin
				busy <= 1'b0;
				idx <= '0;
			end else begin
				idx <= idx + 3'd1;
			end
		end
	end

endmodule

/* logic/fx2_timetag.sv */
`timescale 1ns/1ps
`include "timetag_settings.svh"

module fx2_timetag (
	input  logic                    fx2_clk,
	input  logic                    rst,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  logic [7:0]              paddr,
	input  logic [31:0]             pwdata,
	output logic [31:0]             prdata,
	output logic                    pready,
	output logic                    pslverr,
	input  timetag_pkg::chan_mask_t strobe_in,
	output logic [7:0]              fd,
	output logic                    slwr_n,
	input  logic                    full_n
);
	import timetag_pkg::*;

	logic       run;
	chan_mask_t enable;
	logic       clear_timer;
	logic       rec_valid;
	record_t    rec;
	record_t    head;
	logic       fifo_full;
	logic       fifo_empty;
	logic       drop;
	logic       pop;

	tagger_regs u_regs (
		.fx2_clk(fx2_clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.drop(drop),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.run(run),
		.enable(enable),
		.clear_timer(clear_timer)
	);

	strobe_tagger u_tagger (
		.fx2_clk(fx2_clk),
		.rst(rst),
		.strobe_in(strobe_in),
		.run(run),
		.enable(enable),
		.clear_timer(clear_timer),
		.full(fifo_full),
		.rec_valid(rec_valid),
		.rec(rec)
	);

	record_fifo #(
		.depth(`TIMETAG_FIFO_DEPTH)
	) u_fifo (
		.fx2_clk(fx2_clk),
		.rst(rst),
		.push(rec_valid),
		.din(rec),
		.pop(pop),
		.dout(head),
		.empty(fifo_empty),
		.full(fifo_full),
		.drop(drop)
	);

	fx2_record_writer u_writer (
		.fx2_clk(fx2_clk),
		.rst(rst),
		.empty(fifo_empty),
		.head(head),
		.full_n(full_n),
		.pop(pop),
		.fd(fd),
		.slwr_n(slwr_n)
	);

endmodule

/* verification/fx2_timetag_tb.sv */
`timescale 1ns/1ps
`include "timetag_settings.svh"

module fx2_timetag_tb;
	import timetag_pkg::*;

	localparam int act_write = 0;
	localparam int act_read = 1;
	localparam int act_strobe = 2;
	localparam int act_throttle = 3;
	localparam int act_drain = 4;
	localparam int wait_limit = 4000;
	localparam int stamp_w = `TIMETAG_TIMER_WIDTH;

	typedef logic [stamp_w-1:0] stamp_t;

	typedef struct {
		int act;
		logic [7:0] target;
		logic [31:0] data;
		int gap;
		logic [31:0] expected;
	} step_t;

	// Stamp is checked as an exact delta, against a bound, or not at all
	typedef struct {
		chan_mask_t mask;
		logic [7:0] seq;
		int delta;
		int bound;
	} model_t;

	logic fx2_clk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	chan_mask_t strobe_in;
	logic [7:0] fd;
	logic slwr_n;
	logic full_n;

	step_t steps[$];
	model_t exp_q[$];
	record_t rx_q[$];
	logic [15:0] lfsr_state;
	logic [$bits(record_t)-1:0] shift;
	int nbytes = 0;
	int cycle = 0;
	int throttle_mode = 0;
	logic run_m;
	chan_mask_t enable_m;
	logic [7:0] seq_m;
	logic stamp_known;
	logic clear_pending;
	int last_cycle;
	int clear_cycle;
	stamp_t last_stamp;

	fx2_timetag dut (.*);

	initial begin
		fx2_clk = 1'b0;
		forever #2 fx2_clk = ~fx2_clk;
	end

	always @(posedge fx2_clk) begin
		cycle = cycle + 1;
	end

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return (s >> 1) ^ (s[0] ? 16'hB400 : 16'h0000);
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_step(lfsr_state);
		end
		return v;
	endfunction

	function automatic logic is_mapped(input logic [7:0] addr);
		return addr == reg_version || addr == reg_control || addr == reg_enable ||
			addr == reg_lost;
	endfunction

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			abort_run($sformatf("error at time %0t: %s expected %h got %h", $time, name, exp, got));
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			abort_run($sformatf("error at time %0t: %s expected %0d got %0d", $time, name, exp, got));
		end
	endtask

	task automatic check_record(input record_t got, input record_t exp);
		if (got !== exp) begin
			abort_run($sformatf("error at time %0t: record expected %h got %h", $time, exp, got));
		end
	endtask

	// Collect FX2 bytes into records, MSB first
	always @(posedge fx2_clk) begin
		if (!rst && !slwr_n) begin
			if (!full_n) begin
				abort_run("slwr_n was low while the FX2 full flag was asserted");
			end else begin
				shift = {shift[$bits(record_t)-9:0], fd};
				nbytes = nbytes + 1;
				if (nbytes == record_bytes) begin
					rx_q.push_back(record_t'(shift));
					nbytes = 0;
				end
			end
		end
	end

	// FX2 full flag: free, random or held full
	initial begin
		full_n = 1'b1;
		forever begin
			@(negedge fx2_clk);
			case (throttle_mode)
				1: full_n = rand_bits(1) != 0;
				2: full_n = 1'b0;
				default: full_n = 1'b1;
			endcase
		end
	end

	task automatic apb_transfer(input logic write, input logic [7:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int waited;
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = wdata;
		@(negedge fx2_clk);
		penable = 1'b1;
		waited = 0;
		do begin
			@(posedge fx2_clk);
			waited++;
		end while (!pready && waited < wait_limit);
		if (!pready) begin
			abort_run("APB transfer never saw pready");
		end else begin
			rdata = prdata;
			err = pslverr;
			@(negedge fx2_clk);
			psel = 1'b0;
			penable = 1'b0;
			pwrite = 1'b0;
		end
	endtask

	function automatic void track_write(input logic [7:0] addr, input logic [31:0] data);
		if (addr == reg_control) begin
			run_m = data[0];
			if (!data[0] || data[1]) begin
				stamp_known = 1'b0;
			end
			if (data[1]) begin
				clear_pending = 1'b1;
				clear_cycle = cycle;
			end
		end else if (addr == reg_enable) begin
			enable_m = data[`TIMETAG_CHANNELS-1:0];
		end
	endfunction

	task automatic pulse_strobe(input chan_mask_t m);
		chan_mask_t hit;
		int now;
		model_t e;
		strobe_in = m;
		now = cycle;
		hit = m & enable_m;
		@(negedge fx2_clk);
		strobe_in = '0;
		// A stalled writer plus a full FIFO drops the record
		if (run_m && hit != '0 && !(throttle_mode == 2 &&
				exp_q.size() - rx_q.size() == `TIMETAG_FIFO_DEPTH + 1)) begin
			e.mask = hit;
			e.seq = seq_m;
			e.delta = stamp_known ? now - last_cycle : -1;
			e.bound = clear_pending ? now - clear_cycle + 3 : -1;
			exp_q.push_back(e);
			seq_m = seq_m + 8'd1;
			last_cycle = now;
			stamp_known = 1'b1;
			clear_pending = 1'b0;
		end
	endtask

	task automatic set_throttle(input int mode);
		@(posedge fx2_clk);
		throttle_mode = mode;
		@(negedge fx2_clk);
	endtask

	task automatic drain_and_check();
		int waited;
		model_t e;
		record_t got;
		record_t want;
		waited = 0;
		while (rx_q.size() < exp_q.size() && waited < wait_limit) begin
			@(negedge fx2_clk);
			waited++;
		end
		if (rx_q.size() < exp_q.size()) begin
			abort_run("timed out waiting for records on the FX2 port");
		end else begin
			// Room for an unexpected record to show up
			repeat (24) @(negedge fx2_clk);
			check_count("record count", rx_q.size(), exp_q.size());
			while (exp_q.size() > 0) begin
				e = exp_q.pop_front();
				got = rx_q.pop_front();
				want.mask = e.mask;
				want.seq = e.seq;
				want.stamp = (e.delta >= 0) ? last_stamp + stamp_t'(e.delta) : got.stamp;
				if (e.bound >= 0 && got.stamp > stamp_t'(e.bound)) begin
					abort_run("first stamp after a timer clear is too large");
				end
				check_record(got, want);
				last_stamp = got.stamp;
			end
		end
	endtask

	task automatic add_row(input int act, input logic [7:0] target, input logic [31:0] data,
			input int gap, input logic [31:0] expected);
		step_t s;
		s.act = act;
		s.target = target;
		s.data = data;
		s.gap = gap;
		s.expected = expected;
		steps.push_back(s);
	endtask

	task automatic build_steps();
		// Register map after reset, then unmapped accesses
		add_row(act_read, reg_version, 0, 1, `TIMETAG_VERSION);
		add_row(act_read, reg_control, 0, 1, 0);
		add_row(act_read, reg_enable, 0, 1, 0);
		add_row(act_read, reg_lost, 0, 1, 0);
		add_row(act_read, 8'h10, 0, 1, 0);
		add_row(act_write, 8'h3C, 32'h1, 1, 0);
		// Channels 0 and 2 enabled
		add_row(act_write, reg_enable, 32'h5, 1, 0);
		add_row(act_write, reg_control, 32'h1, 1, 0);
		add_row(act_read, reg_enable, 0, 1, 32'h5);
		add_row(act_strobe, 8'h1, 0, 3, 0);
		add_row(act_strobe, 8'h2, 0, 3, 0);
		add_row(act_strobe, 8'h5, 0, 4, 0);
		add_row(act_strobe, 8'hF, 0, 5, 0);
		add_row(act_drain, 0, 0, 0, 0);
		// Timer clear, then random gaps
		add_row(act_write, reg_control, 32'h3, 1, 0);
		add_row(act_read, reg_control, 0, 1, 32'h1);
		add_row(act_strobe, 8'h4, 0, 6, 0);
		for (int n = 0; n < 5; n++) begin
			add_row(act_strobe, 8'(rand_bits(4)), 0, 1 + rand_bits(3), 0);
		end
		add_row(act_drain, 0, 0, 0, 0);
		// Random back-pressure
		add_row(act_throttle, 0, 1, 0, 0);
		for (int n = 0; n < 6; n++) begin
			add_row(act_strobe, 8'(rand_bits(4)), 0, 1 + rand_bits(3), 0);
		end
		add_row(act_drain, 0, 0, 0, 0);
		add_row(act_throttle, 0, 0, 0, 0);
		// Overflow by three records with full_n held low
		add_row(act_throttle, 0, 2, 0, 0);
		for (int n = 0; n < `TIMETAG_FIFO_DEPTH + 4; n++) begin
			add_row(act_strobe, 8'h1, 0, 2, 0);
		end
		add_row(act_read, reg_lost, 0, 4, 32'd3);
		add_row(act_write, reg_lost, 32'h0, 1, 0);
		add_row(act_read, reg_lost, 0, 1, 32'd0);
		add_row(act_throttle, 0, 0, 0, 0);
		add_row(act_drain, 0, 0, 0, 0);
		// Stopped timer, no records
		add_row(act_write, reg_control, 32'h0, 1, 0);
		add_row(act_strobe, 8'h1, 0, 3, 0);
		add_row(act_strobe, 8'h5, 0, 3, 0);
		add_row(act_drain, 0, 0, 0, 0);
		add_row(act_read, reg_control, 0, 1, 32'h0);
	endtask

	task automatic run_step(input step_t s);
		logic [31:0] rdata;
		logic err;
		repeat (s.gap) @(negedge fx2_clk);
		case (s.act)
			act_write: begin
				apb_transfer(1'b1, s.target, s.data, rdata, err);
				check_count("pslverr", int'(err), int'(!is_mapped(s.target)));
				track_write(s.target, s.data);
			end
			act_read: begin
				apb_transfer(1'b0, s.target, 32'd0, rdata, err);
				check_count("pslverr", int'(err), int'(!is_mapped(s.target)));
				if (is_mapped(s.target)) begin
					check_word("prdata", rdata, s.expected);
				end
			end
			act_strobe: pulse_strobe(s.target[`TIMETAG_CHANNELS-1:0]);
			act_throttle: set_throttle(int'(s.data));
			default: drain_and_check();
		endcase
	endtask

	initial begin
		lfsr_state = 16'd62;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		strobe_in = '0;
		run_m = 1'b0;
		enable_m = '0;
		seq_m = '0;
		stamp_known = 1'b0;
		clear_pending = 1'b0;
		last_cycle = 0;
		clear_cycle = 0;
		last_stamp = '0;
		build_steps();
		repeat (2) @(negedge fx2_clk);
		rst = 1'b0;
		foreach (steps[i]) begin
			run_step(steps[i]);
		end
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

/* all.f */
+incdir+logic
logic/timetag_pkg.sv
logic/tagger_regs.sv
logic/strobe_tagger.sv
logic/record_fifo.sv
logic/fx2_record_writer.sv
logic/fx2_timetag.sv
verification/fx2_timetag_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal -f all.f --top-module fx2_timetag_tb > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vfx2_timetag_tb > sim.log 2>&1
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL CHECKS PASSED" sim.log || { echo "simulation ended without passing"; exit 1; }
echo "simulation passed"
